/* build.f */
logic/lsu_pkg.sv
logic/lsu_req_queue.sv
logic/lsu.sv
logic/load_align.sv
logic/axi_sram.sv
logic/mem_stage.sv
test/mem_stage_assert.sv
test/mem_stage_tb.sv

/* test/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb
    import lsu_pkg::*;
;

    localparam int    CLK_PERIOD = 40;
    localparam addr_t RAM_BASE   = 32'h8000_0000;
    localparam int    RAM_WORDS  = 256;
    localparam addr_t RAM_BYTES  = addr_t'(RAM_WORDS * 4);
    localparam int    N_RANDOM   = 300;
    localparam int    TOTAL_REQS = 2 * RAM_WORDS + 24 + 8 + 16 + N_RANDOM;
    localparam int    WATCHDOG   = (TOTAL_REQS * 40 + 1000) * CLK_PERIOD;
    localparam addr_t W0 = RAM_BASE + 32'h100;
    localparam addr_t W1 = RAM_BASE + 32'h104;
    localparam addr_t W2 = RAM_BASE + 32'h108;

    logic     clk;
    logic     rst;
    logic     req_valid;
    logic     req_ready;
    mem_req_t req;
    logic     wb_valid;
    logic     wb_ready;
    wb_t      wb;

    logic [7:0] ref_mem [RAM_BYTES];   // Mirror of the SRAM bytes
    wb_t        exp_q [$];
    wb_t        exp_wb;
    int         err_count = 0;
    int         n_sent = 0;
    int         n_recv = 0;
    logic       stall_en = 1'b0;
    int         stall_left = 0;

    mem_stage #(
        .RAM_BASE  (RAM_BASE),
        .RAM_WORDS (RAM_WORDS)
    ) mem_stage_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .wb_valid  (wb_valid),
        .wb_ready  (wb_ready),
        .wb        (wb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t fill_word(addr_t a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic mem_req_t make_req(mem_op_t op, mem_size_t size, logic sign,
                                          addr_t addr, word_t data);
        mem_req_t r;
        r.op   = op;
        r.size = size;
        r.sign = sign;
        r.addr = addr;
        r.data = data;
        return r;
    endfunction

    function automatic logic req_fault(mem_req_t r);
        logic mis;
        logic outside;
        mis = (r.size == SZ_HALF && r.addr[0]) || (r.size == SZ_WORD && r.addr[1:0] != 2'b00);
        outside = (r.addr - RAM_BASE) >= RAM_BYTES;
        return (r.op != OP_NONE) && (mis || outside);
    endfunction

    function automatic int size_bytes(mem_size_t s);
        return (s == SZ_BYTE) ? 1 : (s == SZ_HALF) ? 2 : 4;
    endfunction

    function automatic wb_t ref_result(mem_req_t r);
        wb_t   e;
        addr_t off;
        word_t raw;
        e.addr   = r.addr;
        e.fault  = req_fault(r);
        e.result = '0;
        off = r.addr - RAM_BASE;
        if (r.op == OP_NONE) begin
            e.result = r.addr;
        end else if (r.op == OP_LOAD && !e.fault) begin
            raw = '0;
            for (int i = 0; i < size_bytes(r.size); i++) begin
                raw[i*8 +: 8] = ref_mem[off + i];
            end
            if (r.sign && r.size == SZ_BYTE) raw = {{24{raw[7]}}, raw[7:0]};
            if (r.sign && r.size == SZ_HALF) raw = {{16{raw[15]}}, raw[15:0]};
            e.result = raw;
        end
        return e;
    endfunction

    function automatic void apply_store(mem_req_t r);
        addr_t off;
        off = r.addr - RAM_BASE;
        if (r.op == OP_STORE && !req_fault(r)) begin
            for (int i = 0; i < size_bytes(r.size); i++) begin
                ref_mem[off + i] = r.data[i*8 +: 8];
            end
        end
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            err_count++;
        end
    endtask

    task automatic check_fault(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            err_count++;
        end
    endtask

    // Called and returns 2 ns after a rising edge
    task automatic send_req(input mem_req_t r);
        exp_q.push_back(ref_result(r));
        apply_store(r);
        req_valid = 1'b1;
        req       = r;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        n_sent++;
    endtask

    task automatic wait_drain();
        while (n_recv != n_sent) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #2;
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%s finished with %0d errors", name, err_count - errs_before);
    endtask

    // Compare at the falling edge, where wb and the handshake are settled
    always @(negedge clk) begin
        if (!rst && wb_valid && wb_ready) begin
            if (exp_q.size() == 0) begin
                $display("A result arrived with no request pending at %0t", $time);
                err_count++;
            end else begin
                exp_wb = exp_q.pop_front();
                check_word("wb.addr", wb.addr, exp_wb.addr);
                check_word("wb.result", wb.result, exp_wb.result);
                check_fault("wb.fault", wb.fault, exp_wb.fault);
            end
            n_recv++;
        end
    end

    // Writeback back-pressure in random stretches
    always @(posedge clk) begin
        #2;
        if (!stall_en) begin
            wb_ready = 1'b1;
        end else if (stall_left == 0) begin
            wb_ready   = ($urandom % 2) == 0;
            stall_left = $urandom_range(8, 1);
        end else begin
            stall_left--;
        end
    end

    initial begin
        #(WATCHDOG);
        $display("Timeout: results stopped arriving before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        addr_t a;
        word_t d;
        int    t0;
        int    total;
        void'($urandom(63));
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        wb_ready  = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        t0 = err_count;
        @(posedge clk);
        #2;
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("req_ready", req_ready, 1'b1);
        report_test("reset state", t0);

        t0 = err_count;
        for (int i = 0; i < RAM_WORDS; i++) begin
            a = RAM_BASE + addr_t'(i * 4);
            send_req(make_req(OP_STORE, SZ_WORD, 1'b0, a, fill_word(a)));
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, RAM_BASE + addr_t'(i * 4), '0));
        end
        wait_drain();
        report_test("word store and load", t0);

        t0 = err_count;
        for (int off = 0; off < 4; off++) begin
            d    = $urandom;
            d[7] = (off % 2 == 0);   // Both signs among the lanes
            send_req(make_req(OP_STORE, SZ_BYTE, 1'b0, W0 + off, d));
            send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, W0, '0));   // Other lanes kept
        end
        for (int off = 0; off < 4; off += 2) begin
            d     = $urandom;
            d[15] = (off == 0);
            send_req(make_req(OP_STORE, SZ_HALF, 1'b0, W1 + off, d));
            send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, W1, '0));
        end
        for (int off = 0; off < 4; off++) begin
            send_req(make_req(OP_LOAD, SZ_BYTE, 1'b1, W0 + off, '0));
            send_req(make_req(OP_LOAD, SZ_BYTE, 1'b0, W0 + off, '0));
        end
        for (int off = 0; off < 4; off += 2) begin
            send_req(make_req(OP_LOAD, SZ_HALF, 1'b1, W1 + off, '0));
            send_req(make_req(OP_LOAD, SZ_HALF, 1'b0, W1 + off, '0));
        end
        wait_drain();
        report_test("byte and halfword lanes", t0);

        t0 = err_count;
        for (int i = 0; i < 8; i++) begin
            send_req(make_req(OP_NONE, mem_size_t'($urandom_range(2, 0)), 1'b0,
                              $urandom, $urandom));
        end
        wait_drain();
        report_test("pass-through", t0);

        t0 = err_count;
        for (int k = 0; k < 3; k++) begin
            a = (k == 0) ? RAM_BASE - 4 : (k == 1) ? RAM_BASE + RAM_BYTES : 32'h1000_0000;
            send_req(make_req(OP_STORE, SZ_WORD, 1'b0, a, $urandom));
            send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, a, '0));
        end
        // Words the stray stores would land on if wrapped into the array
        send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, RAM_BASE, '0));
        send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, RAM_BASE + RAM_BYTES - 4, '0));
        for (int off = 1; off < 4; off++) begin
            send_req(make_req(OP_STORE, SZ_WORD, 1'b0, W2 + off, $urandom));
        end
        send_req(make_req(OP_STORE, SZ_HALF, 1'b0, W2 + 1, $urandom));
        send_req(make_req(OP_STORE, SZ_HALF, 1'b0, W2 + 3, $urandom));
        send_req(make_req(OP_LOAD, SZ_HALF, 1'b1, W2 + 1, '0));
        send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, W2 + 2, '0));
        send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, W2, '0));   // Memory untouched
        wait_drain();
        report_test("faults", t0);

        t0 = err_count;
        stall_en = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            a = ($urandom % 8 == 0) ? addr_t'($urandom) : RAM_BASE + ($urandom % RAM_BYTES);
            send_req(make_req(mem_op_t'($urandom_range(2, 0)),
                              mem_size_t'($urandom_range(2, 0)),
                              1'($urandom_range(1, 0)), a, $urandom));
        end
        wait_drain();
        stall_en = 1'b0;
        report_test("random mix with back-pressure", t0);

        repeat (4) @(posedge clk);
        if (n_recv != n_sent || exp_q.size() != 0) begin
            $display("Result count does not match request count");
            err_count++;
        end
        total = err_count + mem_stage_i.lsu_i.mem_stage_assert_i.fail_count;
        $display("requests %0d, results %0d, errors %0d", n_sent, n_recv, total);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* test/mem_stage_assert.sv */
`timescale 1ns/1ps

module mem_stage_assert
    import lsu_pkg::*;
#(
    parameter addr_t RAM_BASE  = 32'h8000_0000,
    parameter int    RAM_WORDS = 256
) (
    input logic     clk,
    input logic     rst,
    input axi_aw_t  aw,
    input logic     awvalid,
    input logic     awready,
    input axi_w_t   w,
    input logic     wvalid,
    input logic     wready,
    input axi_ar_t  ar,
    input logic     arvalid,
    input logic     arready,
    input lsu_rsp_t rsp,
    input logic     rsp_valid,
    input logic     rsp_ready
);

    localparam addr_t RAM_BYTES = addr_t'(RAM_WORDS * 4);

    int fail_count = 0;   // Read by the testbench

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            $error("aw dropped or changed before handshake");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(w))
        else begin
            $error("w dropped or changed before handshake");
            fail_count++;
        end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            $error("ar dropped or changed before handshake");
            fail_count++;
        end

    rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            $error("rsp dropped or changed before handshake");
            fail_count++;
        end

    // INCR inside the RAM window, FIXED elsewhere
    aw_burst: assert property (@(posedge clk) disable iff (rst)
        awvalid |-> aw.burst == (((aw.addr - RAM_BASE) < RAM_BYTES) ? BURST_INCR : BURST_FIXED))
        else begin
            $error("aw burst type does not match address window");
            fail_count++;
        end

    ar_burst: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> ar.burst == (((ar.addr - RAM_BASE) < RAM_BYTES) ? BURST_INCR : BURST_FIXED))
        else begin
            $error("ar burst type does not match address window");
            fail_count++;
        end

endmodule

bind lsu mem_stage_assert #(
    .RAM_BASE  (RAM_BASE),
    .RAM_WORDS (RAM_WORDS)
) mem_stage_assert_i (
    .clk       (clk),
    .rst       (rst),
    .aw        (aw),
    .awvalid   (awvalid),
    .awready   (awready),
    .w         (w),
    .wvalid    (wvalid),
    .wready    (wready),
    .ar        (ar),
    .arvalid   (arvalid),
    .arready   (arready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
);

/* logic/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage
    import lsu_pkg::*;
#(
    parameter addr_t RAM_BASE  = 32'h8000_0000,
    parameter int    RAM_WORDS = 256
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_t req,
    output logic     wb_valid,
    input  logic     wb_ready,
    output wb_t      wb
);

    logic     q_valid;
    logic     q_ready;
    mem_req_t q_req;
    logic     rsp_valid;
    logic     rsp_ready;
    lsu_rsp_t rsp;

    axi_aw_t aw;
    logic    awvalid;
    logic    awready;
    axi_w_t  w;
    logic    wvalid;
    logic    wready;
    axi_b_t  b;
    logic    bvalid;
    logic    bready;
    axi_ar_t ar;
    logic    arvalid;
    logic    arready;
    axi_r_t  r;
    logic    rvalid;
    logic    rready;

    lsu_req_queue lsu_req_queue_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_req    (req),
        .out_valid (q_valid),
        .out_ready (q_ready),
        .out_req   (q_req)
    );

    lsu #(
        .RAM_BASE  (RAM_BASE),
        .RAM_WORDS (RAM_WORDS)
    ) lsu_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (q_valid),
        .req_ready (q_ready),
        .req       (q_req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .b         (b),
        .bvalid    (bvalid),
        .bready    (bready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    load_align load_align_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (rsp_valid),
        .in_ready  (rsp_ready),
        .in_rsp    (rsp),
        .out_valid (wb_valid),
        .out_ready (wb_ready),
        .out_wb    (wb)
    );

    axi_sram #(
        .RAM_BASE  (RAM_BASE),
        .RAM_WORDS (RAM_WORDS)
    ) axi_sram_i (
        .clk     (clk),
        .rst     (rst),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

/* logic/axi_sram.sv */
`timescale 1ns/1ps

module axi_sram
    import lsu_pkg::*;
#(
    parameter addr_t RAM_BASE  = 32'h8000_0000,
    parameter int    RAM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst,

    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output axi_b_t  b,
    output logic    bvalid,
    input  logic    bready,
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready
);

    localparam int    IDX_W     = $clog2(RAM_WORDS);
    localparam addr_t RAM_BYTES = addr_t'(RAM_WORDS * 4);

    word_t      mem [RAM_WORDS];
    logic       aw_got;
    logic       w_got;
    axi_aw_t    aw_q;
    axi_w_t     w_q;
    logic       aw_fire;
    logic       w_fire;
    logic       ar_fire;
    logic       wr_go;
    addr_t      wr_off;
    logic [3:0] wr_id;
    axi_w_t     wr_beat;
    logic       wr_hit;
    addr_t      rd_off;
    logic       rd_hit;

    // Write side stalls until the response has gone
    assign awready = !aw_got && !bvalid;
    assign wready  = !w_got && !bvalid;
    assign arready = !rvalid;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign ar_fire = arvalid && arready;

    // Use held address or data when the other channel came later
    assign wr_go   = (aw_got || aw_fire) && (w_got || w_fire);
    assign wr_off  = (aw_got ? aw_q.addr : aw.addr) - RAM_BASE;
    assign wr_id   = aw_got ? aw_q.id : aw.id;
    assign wr_beat = w_got ? w_q : w;
    assign wr_hit  = wr_off < RAM_BYTES;

    assign rd_off = ar.addr - RAM_BASE;
    assign rd_hit = rd_off < RAM_BYTES;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_go) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
            end else begin
                if (aw_fire) begin
                    aw_got <= 1'b1;
                end
                if (w_fire) begin
                    w_got <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_q <= aw;
        end
        if (w_fire) begin
            w_q <= w;
        end
        if (wr_go) begin
            b.resp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
            b.id   <= wr_id;
            if (wr_hit) begin
                for (int i = 0; i < 4; i++) begin
                    if (wr_beat.strb[i]) begin
                        mem[wr_off[IDX_W+1:2]][i*8 +: 8] <= wr_beat.data[i*8 +: 8];
                    end
                end
            end
        end
        if (ar_fire) begin
            r.data <= rd_hit ? mem[rd_off[IDX_W+1:2]] : '0;
            r.resp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
            r.last <= 1'b1;
            r.id   <= ar.id;
        end
    end

endmodule

/* logic/load_align.sv */
`timescale 1ns/1ps

module load_align
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  lsu_rsp_t in_rsp,
    output logic     out_valid,
    input  logic     out_ready,
    output wb_t      out_wb
);

    wb_t   wb_next;
    word_t shifted;

    assign in_ready = !out_valid || out_ready;
    assign shifted  = in_rsp.rdata >> {in_rsp.addr[1:0], 3'b000};   // Lane to bit 0

    always_comb begin
        wb_next.addr   = in_rsp.addr;
        wb_next.fault  = in_rsp.fault;
        wb_next.result = '0;
        case (in_rsp.op)
            OP_LOAD: begin
                if (!in_rsp.fault) begin
                    case (in_rsp.size)
                        SZ_BYTE: wb_next.result = in_rsp.sign ?
                                                  {{24{shifted[7]}}, shifted[7:0]} :
                                                  {24'b0, shifted[7:0]};
                        SZ_HALF: wb_next.result = in_rsp.sign ?
                                                  {{16{shifted[15]}}, shifted[15:0]} :
                                                  {16'b0, shifted[15:0]};
                        default: wb_next.result = in_rsp.rdata;
                    endcase
                end
            end
            OP_NONE: wb_next.result = in_rsp.addr;
            default: wb_next.result = '0;   // Stores return nothing
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_wb <= wb_next;
        end
    end

endmodule

/* logic/lsu.sv */
`timescale 1ns/1ps

module lsu
    import lsu_pkg::*;
#(
    parameter addr_t RAM_BASE  = 32'h8000_0000,
    parameter int    RAM_WORDS = 256
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_t req,

    output logic     rsp_valid,
    input  logic     rsp_ready,
    output lsu_rsp_t rsp,

    output axi_aw_t  aw,
    output logic     awvalid,
    input  logic     awready,
    output axi_w_t   w,
    output logic     wvalid,
    input  logic     wready,
    input  axi_b_t   b,
    input  logic     bvalid,
    output logic     bready,
    output axi_ar_t  ar,
    output logic     arvalid,
    input  logic     arready,
    input  axi_r_t   r,
    input  logic     rvalid,
    output logic     rready
);

    localparam addr_t RAM_BYTES = addr_t'(RAM_WORDS * 4);

    lsu_state_t state;
    logic       req_fire;
    logic [1:0] offset;
    logic       misaligned;
    logic       in_window;
    strb_t      strb_base;
    logic       aw_done;
    logic       w_done;
    logic [1:0] burst;

    assign req_ready = (state == S_IDLE);
    assign req_fire  = req_valid && req_ready;
    assign offset    = req.addr[1:0];
    assign in_window = (req.addr - RAM_BASE) < RAM_BYTES;   // Wraps below base
    assign burst     = in_window ? BURST_INCR : BURST_FIXED;

    // Natural alignment only matters for bus accesses
    assign misaligned = (req.op != OP_NONE) &&
                        ((req.size == SZ_HALF && offset[0]) ||
                         (req.size == SZ_WORD && offset != 2'b00));

    always_comb begin
        case (req.size)
            SZ_BYTE: strb_base = 4'b0001;
            SZ_HALF: strb_base = 4'b0011;
            SZ_WORD: strb_base = 4'b1111;
            default: strb_base = 4'b0000;
        endcase
    end

    // A channel is done once its valid is gone or is being taken
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            arvalid   <= 1'b0;
            bready    <= 1'b0;
            rready    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_fire) begin
                        if (!misaligned && req.op == OP_LOAD) begin
                            state   <= S_ADDR;
                            arvalid <= 1'b1;
                        end else if (!misaligned && req.op == OP_STORE) begin
                            state   <= S_ADDR;
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                        end else begin
                            state     <= S_RESP;   // No bus access
                            rsp_valid <= 1'b1;
                        end
                    end
                end
                S_ADDR: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= S_RESP;
                    end
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                    end
                    if ((awvalid || wvalid) && aw_done && w_done) begin
                        bready <= 1'b1;
                        state  <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (rvalid && rready) begin
                        rready    <= 1'b0;
                        rsp_valid <= 1'b1;
                    end
                    if (bvalid && bready) begin
                        bready    <= 1'b0;
                        rsp_valid <= 1'b1;
                    end
                    if (rsp_valid && rsp_ready) begin
                        rsp_valid <= 1'b0;
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request, bus payload and response record
    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp.op    <= req.op;
            rsp.size  <= req.size;
            rsp.sign  <= req.sign;
            rsp.addr  <= req.addr;
            rsp.rdata <= '0;
            rsp.fault <= misaligned;

            aw.addr  <= req.addr;
            aw.id    <= AXI_ID;
            aw.len   <= 8'd0;   // Single beat
            aw.size  <= AXI_SIZE_WORD;
            aw.burst <= burst;

            ar.addr  <= req.addr;
            ar.id    <= AXI_ID;
            ar.len   <= 8'd0;
            ar.size  <= AXI_SIZE_WORD;
            ar.burst <= burst;

            w.data <= req.data << {offset, 3'b000};
            w.strb <= strb_base << offset;
            w.last <= 1'b1;
        end
        if (rvalid && rready) begin
            rsp.rdata <= r.data;
            rsp.fault <= (r.resp != RESP_OKAY);
        end
        if (bvalid && bready) begin
            rsp.fault <= (b.resp != RESP_OKAY);
        end
    end

endmodule

/* logic/lsu_req_queue.sv */
`timescale 1ns/1ps

module lsu_req_queue
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  mem_req_t in_req,
    output logic     out_valid,
    input  logic     out_ready,
    output mem_req_t out_req
);

    mem_req_t   entry [2];
    logic       rd_ptr;
    logic       wr_ptr;
    logic [1:0] count;
    logic       in_fire;
    logic       out_fire;

    assign in_ready  = (count != 2'd2);   // Full only with both entries taken
    assign out_valid = (count != 2'd0);
    assign out_req   = entry[rd_ptr];

    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= 1'b0;
            wr_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (in_fire) begin
                wr_ptr <= ~wr_ptr;
            end
            if (out_fire) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({in_fire, out_fire})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (in_fire) begin
            entry[wr_ptr] <= in_req;
        end
    end

endmodule

/* logic/lsu_pkg.sv */
package lsu_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    typedef enum logic [1:0] {OP_NONE, OP_LOAD, OP_STORE} mem_op_t;
    typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} mem_size_t;
    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_RESP} lsu_state_t;

    localparam logic [3:0] AXI_ID        = 4'h0;
    localparam logic [2:0] AXI_SIZE_WORD = 3'h2;
    localparam logic [1:0] BURST_FIXED   = 2'b00;
    localparam logic [1:0] BURST_INCR    = 2'b01;
    localparam resp_t      RESP_OKAY     = 2'b00;
    localparam resp_t      RESP_SLVERR   = 2'b10;

    typedef struct packed {
        mem_op_t   op;
        mem_size_t size;
        logic      sign;   // Sign-extend loads
        addr_t     addr;
        word_t     data;   // Store data, unshifted
    } mem_req_t;

    typedef struct packed {
        mem_op_t   op;
        mem_size_t size;
        logic      sign;
        addr_t     addr;
        word_t     rdata;  // Raw bus word
        logic      fault;
    } lsu_rsp_t;

    typedef struct packed {
        addr_t addr;
        word_t result;
        logic  fault;
    } wb_t;

    typedef struct packed {
        addr_t      addr;
        logic [3:0] id;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_aw_t;

    typedef struct packed {
        addr_t      addr;
        logic [3:0] id;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        resp_t      resp;
        logic [3:0] id;
    } axi_b_t;

    typedef struct packed {
        word_t      data;
        resp_t      resp;
        logic       last;
        logic [3:0] id;
    } axi_r_t;

endpackage
